//--- xbus_params.svh
`ifndef XBUS_PARAMS_SVH
`define XBUS_PARAMS_SVH

// Xbus word address and data widths.
`define XBUS_ADDR_W 22
`define XBUS_DATA_W 32

// First address outside the RAM window.
`define XBUS_RAM_LIMIT 22'o11000000

// Storage array depth as a power of two.
`define SDRAM_DEPTH_LOG2 10

// Refresh spacing and length, in clock cycles.
`define REFRESH_INTERVAL 64
`define REFRESH_CYCLES 6

`endif

//--- xbus_pkg.sv
`default_nettype none

`include "xbus_params.svh"

package xbus_pkg;

   // One Xbus word address.
   typedef logic [`XBUS_ADDR_W-1:0] xbus_addr_t;

   // One Xbus data word.
   typedef logic [`XBUS_DATA_W-1:0] xbus_data_t;

   // Memory operation in flight.
   // Also the wait state of the bus slave.
   typedef enum logic [1:0]
   {
      MEM_IDLE  = 2'd0,
      MEM_WRITE = 2'd1,
      MEM_READ  = 2'd2
   } mem_op_t;

endpackage

`default_nettype wire

//--- sdram_if.sv
`timescale 1ns/1ps
`default_nettype none

interface sdram_if;

   // Request side, held by the bus slave until completion.
   xbus_pkg::xbus_addr_t sdram_addr;
   xbus_pkg::xbus_data_t sdram_data_out;
   logic                 sdram_req;
   logic                 sdram_write;

   // Completion side, driven by the memory controller.
   xbus_pkg::xbus_data_t sdram_data_in;
   logic                 sdram_ready;
   logic                 sdram_done;

   modport bridge
   (
      output sdram_addr,
      output sdram_data_out,
      output sdram_req,
      output sdram_write,
      input  sdram_data_in,
      input  sdram_ready,
      input  sdram_done
   );

   modport ctrl
   (
      input  sdram_addr,
      input  sdram_data_out,
      input  sdram_req,
      input  sdram_write,
      output sdram_data_in,
      output sdram_ready,
      output sdram_done
   );

endinterface

`default_nettype wire

//--- sdram_array.sv
`timescale 1ns/1ps
`default_nettype none

`include "xbus_params.svh"

module sdram_array
#(
   parameter int SDRAM_DEPTH_LOG2 = `SDRAM_DEPTH_LOG2
)
(
   input  wire                        clk,
   input  wire                        we,
   input  wire [SDRAM_DEPTH_LOG2-1:0] addr,
   input  wire xbus_pkg::xbus_data_t  wdata,
   output xbus_pkg::xbus_data_t       rdata
);

   localparam int DEPTH = 1 << SDRAM_DEPTH_LOG2;

   xbus_pkg::xbus_data_t mem [DEPTH];

   // Single port.
   // A read during a write returns the old word.
   always_ff @(posedge clk)
   begin
      if (we)
      begin
         mem[addr] <= wdata;
      end
      rdata <= mem[addr];
   end

endmodule

`default_nettype wire

//--- sdram_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "xbus_params.svh"

module sdram_ctrl
(
   input  wire                            clk,
   input  wire                            reset,
   sdram_if.ctrl                          mem,
   output logic                           we,
   output logic [`SDRAM_DEPTH_LOG2-1:0]   array_addr,
   output xbus_pkg::xbus_data_t           wdata,
   input  wire xbus_pkg::xbus_data_t      rdata
);

   localparam int REF_W = $clog2(`REFRESH_INTERVAL + `REFRESH_CYCLES);

   xbus_pkg::mem_op_t              op;
   logic [`SDRAM_DEPTH_LOG2-1:0]   addr_q;
   xbus_pkg::xbus_data_t           wdata_q;
   xbus_pkg::xbus_data_t           rdata_q;
   logic                           rd_pending;
   logic                           refresh;
   logic [REF_W-1:0]               ref_cnt;
   logic                           go;

   // Refresh timer.
   // Counts the idle interval, then holds refresh for a fixed length.
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         refresh <= 1'b0;
         ref_cnt <= '0;
      end
      else if (!refresh)
      begin
         if (ref_cnt == REF_W'(`REFRESH_INTERVAL - 1))
         begin
            refresh <= 1'b1;
            ref_cnt <= '0;
         end
         else
         begin
            ref_cnt <= ref_cnt + 1'b1;
         end
      end
      else
      begin
         if (ref_cnt == REF_W'(`REFRESH_CYCLES - 1))
         begin
            refresh <= 1'b0;
            ref_cnt <= '0;
         end
         else
         begin
            ref_cnt <= ref_cnt + 1'b1;
         end
      end
   end

   // A latched request starts as soon as no refresh is running.
   assign go = (op != xbus_pkg::MEM_IDLE) && !refresh;

   // Pending operation and read pipeline.
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         op         <= xbus_pkg::MEM_IDLE;
         rd_pending <= 1'b0;
      end
      else
      begin
         rd_pending <= go && (op == xbus_pkg::MEM_READ);
         if (mem.sdram_write)
         begin
            op <= xbus_pkg::MEM_WRITE;
         end
         else if (mem.sdram_req)
         begin
            op <= xbus_pkg::MEM_READ;
         end
         else if (go)
         begin
            op <= xbus_pkg::MEM_IDLE;
         end
      end
   end

   // Request payload and the held read word.
   always_ff @(posedge clk)
   begin
      if (mem.sdram_write || mem.sdram_req)
      begin
         addr_q  <= mem.sdram_addr[`SDRAM_DEPTH_LOG2-1:0];
         wdata_q <= mem.sdram_data_out;
      end
      if (rd_pending)
      begin
         rdata_q <= rdata;
      end
   end

   // Array side.
   assign we         = go && (op == xbus_pkg::MEM_WRITE);
   assign array_addr = addr_q;
   assign wdata      = wdata_q;

   // Write completes with the commit, read one cycle after the address.
   assign mem.sdram_done  = we;
   assign mem.sdram_ready = rd_pending;

   // Fresh array data in the ready cycle, the held copy afterwards.
   assign mem.sdram_data_in = rd_pending ? rdata : rdata_q;

endmodule

`default_nettype wire

//--- xbus_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "xbus_params.svh"

module xbus_ram
(
   input  wire                        clk,
   input  wire                        reset,
   input  wire xbus_pkg::xbus_addr_t  addr,
   input  wire xbus_pkg::xbus_data_t  datain,
   input  wire                        req,
   input  wire                        write,
   output xbus_pkg::xbus_data_t       dataout,
   output logic                       ack,
   output logic                       decode,
   sdram_if.bridge                    mem
);

   xbus_pkg::mem_op_t state;
   logic              start;
   logic              write_done;
   logic              read_done;
   logic              wr_strobe;
   logic              rd_strobe;

   // Every address below the limit is main memory.
   assign decode = (addr < `XBUS_RAM_LIMIT);

   // Only an idle slave accepts a new access.
   assign start = req && decode && (state == xbus_pkg::MEM_IDLE);

   // Completion counts only in the matching wait state.
   assign write_done = (state == xbus_pkg::MEM_WRITE) && mem.sdram_done;
   assign read_done  = (state == xbus_pkg::MEM_READ) && mem.sdram_ready;
   assign ack        = write_done || read_done;

   // Wait state machine, one strobe per decoded access.
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state     <= xbus_pkg::MEM_IDLE;
         wr_strobe <= 1'b0;
         rd_strobe <= 1'b0;
      end
      else
      begin
         wr_strobe <= start && write;
         rd_strobe <= start && !write;
         if (start)
         begin
            state <= write ? xbus_pkg::MEM_WRITE : xbus_pkg::MEM_READ;
         end
         else if (ack)
         begin
            state <= xbus_pkg::MEM_IDLE;
         end
      end
   end

   assign mem.sdram_write = wr_strobe;
   assign mem.sdram_req   = rd_strobe;

   // The master holds address and data until ack.
   assign mem.sdram_addr     = addr;
   assign mem.sdram_data_out = datain;
   assign dataout            = mem.sdram_data_in;

endmodule

`default_nettype wire

//--- xbus_mem_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "xbus_params.svh"

module xbus_mem_top
(
   input  wire                        clk,
   input  wire                        reset,
   input  wire xbus_pkg::xbus_addr_t  addr,
   input  wire xbus_pkg::xbus_data_t  datain,
   input  wire                        req,
   input  wire                        write,
   output xbus_pkg::xbus_data_t       dataout,
   output logic                       ack,
   output logic                       decode
);

   logic                          we;
   logic [`SDRAM_DEPTH_LOG2-1:0]  array_addr;
   xbus_pkg::xbus_data_t          wdata;
   xbus_pkg::xbus_data_t          rdata;

   // Slave to controller request channel.
   sdram_if mem_bus ();

   xbus_ram u_xbus_ram
   (
      .clk     (clk),
      .reset   (reset),
      .addr    (addr),
      .datain  (datain),
      .req     (req),
      .write   (write),
      .dataout (dataout),
      .ack     (ack),
      .decode  (decode),
      .mem     (mem_bus.bridge)
   );

   sdram_ctrl u_sdram_ctrl
   (
      .clk        (clk),
      .reset      (reset),
      .mem        (mem_bus.ctrl),
      .we         (we),
      .array_addr (array_addr),
      .wdata      (wdata),
      .rdata      (rdata)
   );

   sdram_array
   #(
      .SDRAM_DEPTH_LOG2 (`SDRAM_DEPTH_LOG2)
   )
   u_sdram_array
   (
      .clk   (clk),
      .we    (we),
      .addr  (array_addr),
      .wdata (wdata),
      .rdata (rdata)
   );

endmodule

`default_nettype wire

//--- tb_xbus_checks.svh
`ifndef TB_XBUS_CHECKS_SVH
`define TB_XBUS_CHECKS_SVH

`include "xbus_params.svh"

// Expected storage contents, one entry per array word.
xbus_pkg::xbus_data_t model_mem [int];

// Array word that an Xbus address lands on.
function automatic int model_index(input xbus_pkg::xbus_addr_t a);
   return int'(a % (1 << `SDRAM_DEPTH_LOG2));
endfunction

// Applies one access to the model.
// Returns the expected read word and reports whether the address is decoded.
function automatic xbus_pkg::xbus_data_t model_access
(
   input  xbus_pkg::xbus_addr_t a,
   input  xbus_pkg::xbus_data_t d,
   input  logic                 wr,
   output logic                 dec
);
   int                   idx;
   xbus_pkg::xbus_data_t result;
   dec    = (a < `XBUS_RAM_LIMIT);
   idx    = model_index(a);
   result = 'x;
   if (dec && wr)
   begin
      model_mem[idx] = d;
   end
   else if (dec && model_mem.exists(idx))
   begin
      result = model_mem[idx];
   end
   return result;
endfunction

task automatic check_data
(
   input xbus_pkg::xbus_data_t actual,
   input xbus_pkg::xbus_data_t expected,
   input xbus_pkg::xbus_addr_t a
);
   if (actual !== expected)
   begin
      fail_run($sformatf("[FAIL] %0t dataout at address %o: expected %h, got %h",
                         $time, a, expected, actual));
   end
endtask

task automatic check_decode
(
   input logic                 actual,
   input logic                 expected,
   input xbus_pkg::xbus_addr_t a
);
   if (actual !== expected)
   begin
      fail_run($sformatf("[FAIL] %0t decode at address %o: expected %b, got %b",
                         $time, a, expected, actual));
   end
endtask

// No decoded access is outstanding, so ack must stay low.
task automatic check_ack_absent(input logic actual);
   if (actual !== 1'b0)
   begin
      fail_run($sformatf("[FAIL] %0t ack with no access outstanding: expected 0, got %b",
                         $time, actual));
   end
endtask

`endif

//--- tb_xbus_mem.sv
`timescale 1ns/1ps
`default_nettype none

`include "xbus_params.svh"

module tb_xbus_mem;

   localparam int CLK_PERIOD = 4;
   localparam int ACK_LIMIT  = `REFRESH_INTERVAL + 10;
   localparam int N_RANDOM   = 200;
   localparam int N_PAIRS    = 20;
   // All accesses of the run, plus margin for the idle and decode checks.
   localparam int N_PLANNED  = 2 + N_RANDOM + 3 + 2 * N_PAIRS + 8;
   localparam int WATCHDOG_NS = N_PLANNED * ACK_LIMIT * CLK_PERIOD;

   typedef struct packed
   {
      logic                 is_read;
      xbus_pkg::xbus_data_t data;
   } expect_t;

   logic                 clk;
   logic                 reset;
   xbus_pkg::xbus_addr_t addr;
   xbus_pkg::xbus_data_t datain;
   logic                 req;
   logic                 write;
   xbus_pkg::xbus_data_t dataout;
   logic                 ack;
   logic                 decode;

   integer               seed;
   expect_t              pending [$];
   int                   issued;
   int                   ack_count;

   xbus_mem_top i_dut
   (
      .clk     (clk),
      .reset   (reset),
      .addr    (addr),
      .datain  (datain),
      .req     (req),
      .write   (write),
      .dataout (dataout),
      .ack     (ack),
      .decode  (decode)
   );

   task automatic fail_run(input string reason);
      $display("%s", reason);
      $display("Test FAILED");
      $fatal(1, "Simulation stopped at the first error.");
   endtask

   `include "tb_xbus_checks.svh"

   // Decoded address with its array word drawn from a small pool, so words alias.
   function automatic xbus_pkg::xbus_addr_t random_ram_addr();
      logic [31:0]          r;
      xbus_pkg::xbus_addr_t a;
      r = $random(seed);
      a = xbus_pkg::xbus_addr_t'(r % `XBUS_RAM_LIMIT);
      r = $random(seed);
      a[`SDRAM_DEPTH_LOG2-1:0] = `SDRAM_DEPTH_LOG2'(r % 32);
      return a;
   endfunction

   task automatic wait_ack(input xbus_pkg::xbus_addr_t a);
      int cycles;
      cycles = 0;
      @(negedge clk);
      while (ack !== 1'b1)
      begin
         cycles++;
         if (cycles > ACK_LIMIT)
         begin
            fail_run($sformatf("No ack for the access to address %o within %0d cycles",
                               a, ACK_LIMIT));
         end
         @(negedge clk);
      end
   endtask

   // Starts one access and holds it until ack, or for a fixed time if undecoded.
   task automatic do_access
   (
      input xbus_pkg::xbus_addr_t a,
      input xbus_pkg::xbus_data_t d,
      input logic                 wr
   );
      expect_t item;
      logic    dec;
      item.data    = model_access(a, d, wr, dec);
      item.is_read = !wr;
      if (dec)
      begin
         pending.push_back(item);
         issued++;
      end
      @(posedge clk);
      addr   <= a;
      datain <= d;
      write  <= wr;
      req    <= 1'b1;
      if (dec)
      begin
         wait_ack(a);
      end
      else
      begin
         repeat (ACK_LIMIT)
         begin
            @(negedge clk);
            check_decode(decode, dec, a);
         end
      end
   endtask

   task automatic drop_req();
      @(posedge clk);
      req   <= 1'b0;
      write <= 1'b0;
   endtask

   task automatic decode_probe(input xbus_pkg::xbus_addr_t a);
      logic dec;
      void'(model_access(a, '0, 1'b0, dec));
      @(posedge clk);
      addr <= a;
      req  <= 1'b0;
      @(negedge clk);
      check_decode(decode, dec, a);
   endtask

   initial
   begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   initial
   begin : watchdog
      #(WATCHDOG_NS);
      fail_run("Watchdog expired before the test sequence finished");
   end

   // Decode follows the current address in every cycle.
   // Every ack must match the oldest outstanding access.
   always @(negedge clk)
   begin : compare_acks
      expect_t item;
      logic    exp_dec;
      if (reset === 1'b0)
      begin
         void'(model_access(addr, '0, 1'b0, exp_dec));
         check_decode(decode, exp_dec, addr);
         if (pending.size() == 0)
         begin
            check_ack_absent(ack);
         end
         else if (ack === 1'b1)
         begin
            item = pending.pop_front();
            ack_count++;
            if (item.is_read)
            begin
               check_data(dataout, item.data, addr);
            end
         end
      end
   end

   initial
   begin : stimulus
      xbus_pkg::xbus_addr_t a;
      xbus_pkg::xbus_data_t d;
      logic [31:0]          r;
      logic                 wr;
      seed      = 32'h13e6;
      issued    = 0;
      ack_count = 0;
      reset     = 1'b1;
      addr      = '0;
      datain    = '0;
      req       = 1'b0;
      write     = 1'b0;
      repeat (2) @(posedge clk);
      reset <= 1'b0;

      // Quiet bus after reset, ack is watched by the compare process.
      repeat (8) @(posedge clk);

      decode_probe(`XBUS_RAM_LIMIT - 1);
      decode_probe('0);
      decode_probe(`XBUS_RAM_LIMIT);
      decode_probe({`XBUS_ADDR_W{1'b1}});

      do_access(22'o1234, 32'h5a5a_0001, 1'b1);
      drop_req();
      do_access(22'o1234, '0, 1'b0);
      drop_req();

      for (int i = 0; i < N_RANDOM; i++)
      begin
         a  = random_ram_addr();
         d  = $random(seed);
         r  = $random(seed);
         wr = r[0] || !model_mem.exists(model_index(a));
         do_access(a, d, wr);
         drop_req();
      end

      // Undecoded write onto the same array word leaves it unchanged.
      a = 22'o2345;
      d = 32'hcafe_0042;
      do_access(a, d, 1'b1);
      drop_req();
      do_access(xbus_pkg::xbus_addr_t'(`XBUS_RAM_LIMIT + model_index(a)), ~d, 1'b1);
      drop_req();
      do_access(a, '0, 1'b0);
      drop_req();

      // Back-to-back pairs span several refresh periods.
      for (int i = 0; i < N_PAIRS; i++)
      begin
         a = random_ram_addr();
         d = $random(seed);
         do_access(a, d, 1'b1);
         do_access(a, '0, 1'b0);
      end
      drop_req();

      repeat (5) @(negedge clk);
      if (ack_count != issued)
      begin
         fail_run($sformatf("Saw %0d acks for %0d decoded accesses", ack_count, issued));
      end
      else
      begin
         $display("Test OK");
         $finish;
      end
   end

endmodule

`default_nettype wire

//--- list.f
+incdir+.
xbus_pkg.sv
sdram_if.sv
sdram_array.sv
sdram_ctrl.sv
xbus_ram.sv
xbus_mem_top.sv
tb_xbus_mem.sv

//--- Bender.yml
package:
  name: xbus_mem

export_include_dirs:
  - .

sources:
  - files:
      - xbus_pkg.sv
      - sdram_if.sv
      - sdram_array.sv
      - sdram_ctrl.sv
      - xbus_ram.sv
      - xbus_mem_top.sv
  - target: test
    files:
      - tb_xbus_mem.sv
